// ==== verilog/exec_pkg.sv ====
// widths, sizes and ALU operation codes shared by the execution cluster
// referenced by scoped name from the RTL and the testbench

`default_nettype none

package exec_pkg;

  localparam int DATA_BITS  = 32;
  localparam int TAG_BITS   = 4;
  localparam int RS_ENTRIES = 8;

  // shift amount field of operand b
  localparam int SHAMT_BITS = $clog2(DATA_BITS);

  typedef logic [DATA_BITS-1:0]  data_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [RS_ENTRIES-1:0] rs_vec_t;

  // register-register RV32I integer operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

endpackage

`default_nettype wire

// ==== verilog/rs_dispatch.sv ====
// allocates the lowest free reservation entry for an incoming operation
// and resolves operands whose producer is on the CDB in the same cycle

`timescale 1ns/1ps
`default_nettype none

module rs_dispatch (
  input  wire                     clk_in,
  input  wire                     reset,
  input  wire                     flush,
  input  wire                     in_valid,
  input  wire exec_pkg::alu_op_e  in_op,
  input  wire exec_pkg::tag_t     in_tag,
  input  wire                     in_src1_ready,
  input  wire exec_pkg::tag_t     in_src1_tag,
  input  wire exec_pkg::data_t    in_src1_value,
  input  wire                     in_src2_ready,
  input  wire exec_pkg::tag_t     in_src2_tag,
  input  wire exec_pkg::data_t    in_src2_value,
  input  wire exec_pkg::rs_vec_t  busy,
  input  wire                     cdb_valid,
  input  wire exec_pkg::tag_t     cdb_tag,
  input  wire exec_pkg::data_t    cdb_value,
  output exec_pkg::rs_vec_t       entry_write,
  output exec_pkg::alu_op_e       wr_op,
  output exec_pkg::tag_t          wr_tag,
  output logic                    wr_src1_ready,
  output exec_pkg::tag_t          wr_src1_tag,
  output exec_pkg::data_t         wr_src1_value,
  output logic                    wr_src2_ready,
  output exec_pkg::tag_t          wr_src2_tag,
  output exec_pkg::data_t         wr_src2_value
);

  exec_pkg::rs_vec_t free_vec;

  function automatic logic [exec_pkg::DATA_BITS:0] resolve(
    input logic            ready,
    input exec_pkg::tag_t  tag,
    input exec_pkg::data_t value
  );
    if (ready) return {1'b1, value};
    if (cdb_valid && cdb_tag == tag) return {1'b1, cdb_value};
    return {1'b0, value};
  endfunction

  // lowest set bit of the free vector
  assign free_vec    = ~busy;
  assign entry_write = (in_valid && !flush) ? (free_vec & (~free_vec + 1'b1)) : '0;

  always_comb begin
    wr_op       = in_op;
    wr_tag      = in_tag;
    wr_src1_tag = in_src1_tag;
    wr_src2_tag = in_src2_tag;
    {wr_src1_ready, wr_src1_value} = resolve(in_src1_ready, in_src1_tag, in_src1_value);
    {wr_src2_ready, wr_src2_value} = resolve(in_src2_ready, in_src2_tag, in_src2_value);
  end

endmodule

`default_nettype wire

// ==== verilog/rs_entry.sv ====
// one reservation entry holding an ALU operation until both operands arrive
// operands wake from the CDB, the entry frees itself on grant or flush

`timescale 1ns/1ps
`default_nettype none

module rs_entry (
  input  wire                     clk_in,
  input  wire                     reset,
  input  wire                     flush,
  input  wire                     write,
  input  wire exec_pkg::alu_op_e  wr_op,
  input  wire exec_pkg::tag_t     wr_tag,
  input  wire                     wr_src1_ready,
  input  wire exec_pkg::tag_t     wr_src1_tag,
  input  wire exec_pkg::data_t    wr_src1_value,
  input  wire                     wr_src2_ready,
  input  wire exec_pkg::tag_t     wr_src2_tag,
  input  wire exec_pkg::data_t    wr_src2_value,
  input  wire                     cdb_valid,
  input  wire exec_pkg::tag_t     cdb_tag,
  input  wire exec_pkg::data_t    cdb_value,
  input  wire                     grant,
  output logic                    busy,
  output logic                    ready,
  output exec_pkg::alu_op_e       op,
  output exec_pkg::tag_t          tag,
  output exec_pkg::data_t         src1_value,
  output exec_pkg::data_t         src2_value
);

  logic           src1_ready;
  logic           src2_ready;
  exec_pkg::tag_t src1_tag;
  exec_pkg::tag_t src2_tag;
  logic           src1_wake;
  logic           src2_wake;

  assign src1_wake = busy && !src1_ready && cdb_valid && (cdb_tag == src1_tag);
  assign src2_wake = busy && !src2_ready && cdb_valid && (cdb_tag == src2_tag);

  always_ff @(posedge clk_in) begin
    if (reset || flush) begin
      busy       <= 1'b0;
      src1_ready <= 1'b0;
      src2_ready <= 1'b0;
    end else if (write) begin
      busy       <= 1'b1;
      src1_ready <= wr_src1_ready;
      src2_ready <= wr_src2_ready;
    end else if (grant) begin
      busy <= 1'b0;
    end else begin
      if (src1_wake) src1_ready <= 1'b1;
      if (src2_wake) src2_ready <= 1'b1;
    end
  end

  // held operation and operand values
  always_ff @(posedge clk_in) begin
    if (write) begin
      op         <= wr_op;
      tag        <= wr_tag;
      src1_tag   <= wr_src1_tag;
      src2_tag   <= wr_src2_tag;
      src1_value <= wr_src1_value;
      src2_value <= wr_src2_value;
    end else begin
      if (src1_wake) src1_value <= cdb_value;
      if (src2_wake) src2_value <= cdb_value;
    end
  end

  assign ready = busy && src1_ready && src2_ready;

endmodule

`default_nettype wire

// ==== verilog/rs_issue_select.sv ====
// picks the lowest ready reservation entry each cycle and feeds it to the ALU
// one credit goes back to the sender for every entry granted

`timescale 1ns/1ps
`default_nettype none

module rs_issue_select (
  input  wire                                               clk_in,
  input  wire                                               reset,
  input  wire                                               flush,
  input  wire exec_pkg::rs_vec_t                            ready,
  input  wire exec_pkg::alu_op_e [exec_pkg::RS_ENTRIES-1:0] op,
  input  wire exec_pkg::tag_t    [exec_pkg::RS_ENTRIES-1:0] tag,
  input  wire exec_pkg::data_t   [exec_pkg::RS_ENTRIES-1:0] src1_value,
  input  wire exec_pkg::data_t   [exec_pkg::RS_ENTRIES-1:0] src2_value,
  output exec_pkg::rs_vec_t                                 grant,
  output logic                                              issue_valid,
  output exec_pkg::alu_op_e                                 issue_op,
  output exec_pkg::tag_t                                    issue_tag,
  output exec_pkg::data_t                                   issue_a,
  output exec_pkg::data_t                                   issue_b,
  output logic                                              credit_return
);

  // fixed priority, lowest index wins
  assign grant       = ready & (~ready + 1'b1);
  assign issue_valid = |ready;

  always_comb begin
    issue_op  = exec_pkg::ALU_ADD;
    issue_tag = '0;
    issue_a   = '0;
    issue_b   = '0;
    for (int i = 0; i < exec_pkg::RS_ENTRIES; i++) begin
      if (grant[i]) begin
        issue_op  = op[i];
        issue_tag = tag[i];
        issue_a   = src1_value[i];
        issue_b   = src2_value[i];
      end
    end
  end

  // a grant in a flush cycle frees nothing the sender still counts
  always_ff @(posedge clk_in) begin
    if (reset || flush) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= issue_valid;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/alu_exec.sv ====
// single-stage integer ALU, its registered result is the CDB broadcast
// a flush drops whatever was issued in that cycle

`timescale 1ns/1ps
`default_nettype none

module alu_exec (
  input  wire                     clk_in,
  input  wire                     reset,
  input  wire                     flush,
  input  wire                     issue_valid,
  input  wire exec_pkg::alu_op_e  issue_op,
  input  wire exec_pkg::tag_t     issue_tag,
  input  wire exec_pkg::data_t    issue_a,
  input  wire exec_pkg::data_t    issue_b,
  output logic                    cdb_valid,
  output exec_pkg::tag_t          cdb_tag,
  output exec_pkg::data_t         cdb_value
);

  exec_pkg::data_t                   result;
  logic [exec_pkg::SHAMT_BITS-1:0]   shamt;

  assign shamt = issue_b[exec_pkg::SHAMT_BITS-1:0];

  always_comb begin
    case (issue_op)
      exec_pkg::ALU_ADD:  result = issue_a + issue_b;
      exec_pkg::ALU_SUB:  result = issue_a - issue_b;
      exec_pkg::ALU_AND:  result = issue_a & issue_b;
      exec_pkg::ALU_OR:   result = issue_a | issue_b;
      exec_pkg::ALU_XOR:  result = issue_a ^ issue_b;
      exec_pkg::ALU_SLL:  result = issue_a << shamt;
      exec_pkg::ALU_SRL:  result = issue_a >> shamt;
      exec_pkg::ALU_SRA:  result = $signed(issue_a) >>> shamt;
      exec_pkg::ALU_SLT:  result = exec_pkg::data_t'($signed(issue_a) < $signed(issue_b));
      exec_pkg::ALU_SLTU: result = exec_pkg::data_t'(issue_a < issue_b);
      default:            result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (reset || flush) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= issue_valid;
    end
  end

  // broadcast payload
  always_ff @(posedge clk_in) begin
    if (issue_valid) begin
      cdb_tag   <= issue_tag;
      cdb_value <= result;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exec_cluster.sv ====
// integer execution cluster: dispatch, reservation entries, issue select and ALU
// operations enter under credits, results leave on the CDB

`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
  input  wire                     clk_in,
  input  wire                     reset,
  input  wire                     flush,
  input  wire                     in_valid,
  input  wire exec_pkg::alu_op_e  in_op,
  input  wire exec_pkg::tag_t     in_tag,
  input  wire                     in_src1_ready,
  input  wire exec_pkg::tag_t     in_src1_tag,
  input  wire exec_pkg::data_t    in_src1_value,
  input  wire                     in_src2_ready,
  input  wire exec_pkg::tag_t     in_src2_tag,
  input  wire exec_pkg::data_t    in_src2_value,
  output wire                     credit_return,
  output wire                     cdb_valid,
  output wire exec_pkg::tag_t     cdb_tag,
  output wire exec_pkg::data_t    cdb_value
);

  // dispatch to entries
  wire exec_pkg::rs_vec_t entry_write;
  wire exec_pkg::alu_op_e wr_op;
  wire exec_pkg::tag_t    wr_tag;
  wire                    wr_src1_ready;
  wire exec_pkg::tag_t    wr_src1_tag;
  wire exec_pkg::data_t   wr_src1_value;
  wire                    wr_src2_ready;
  wire exec_pkg::tag_t    wr_src2_tag;
  wire exec_pkg::data_t   wr_src2_value;

  // entries to select
  wire exec_pkg::rs_vec_t                            ent_busy;
  wire exec_pkg::rs_vec_t                            ent_ready;
  wire exec_pkg::rs_vec_t                            grant;
  wire exec_pkg::alu_op_e [exec_pkg::RS_ENTRIES-1:0] ent_op;
  wire exec_pkg::tag_t    [exec_pkg::RS_ENTRIES-1:0] ent_tag;
  wire exec_pkg::data_t   [exec_pkg::RS_ENTRIES-1:0] ent_src1_value;
  wire exec_pkg::data_t   [exec_pkg::RS_ENTRIES-1:0] ent_src2_value;

  // select to alu
  wire                    issue_valid;
  wire exec_pkg::alu_op_e issue_op;
  wire exec_pkg::tag_t    issue_tag;
  wire exec_pkg::data_t   issue_a;
  wire exec_pkg::data_t   issue_b;

  rs_dispatch dispatch (
    .clk_in        (clk_in),
    .reset         (reset),
    .flush         (flush),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_tag        (in_tag),
    .in_src1_ready (in_src1_ready),
    .in_src1_tag   (in_src1_tag),
    .in_src1_value (in_src1_value),
    .in_src2_ready (in_src2_ready),
    .in_src2_tag   (in_src2_tag),
    .in_src2_value (in_src2_value),
    .busy          (ent_busy),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .entry_write   (entry_write),
    .wr_op         (wr_op),
    .wr_tag        (wr_tag),
    .wr_src1_ready (wr_src1_ready),
    .wr_src1_tag   (wr_src1_tag),
    .wr_src1_value (wr_src1_value),
    .wr_src2_ready (wr_src2_ready),
    .wr_src2_tag   (wr_src2_tag),
    .wr_src2_value (wr_src2_value)
  );

  for (genvar i = 0; i < exec_pkg::RS_ENTRIES; i++) begin : g_entry
    rs_entry entry (
      .clk_in        (clk_in),
      .reset         (reset),
      .flush         (flush),
      .write         (entry_write[i]),
      .wr_op         (wr_op),
      .wr_tag        (wr_tag),
      .wr_src1_ready (wr_src1_ready),
      .wr_src1_tag   (wr_src1_tag),
      .wr_src1_value (wr_src1_value),
      .wr_src2_ready (wr_src2_ready),
      .wr_src2_tag   (wr_src2_tag),
      .wr_src2_value (wr_src2_value),
      .cdb_valid     (cdb_valid),
      .cdb_tag       (cdb_tag),
      .cdb_value     (cdb_value),
      .grant         (grant[i]),
      .busy          (ent_busy[i]),
      .ready         (ent_ready[i]),
      .op            (ent_op[i]),
      .tag           (ent_tag[i]),
      .src1_value    (ent_src1_value[i]),
      .src2_value    (ent_src2_value[i])
    );
  end

  rs_issue_select select (
    .clk_in        (clk_in),
    .reset         (reset),
    .flush         (flush),
    .ready         (ent_ready),
    .op            (ent_op),
    .tag           (ent_tag),
    .src1_value    (ent_src1_value),
    .src2_value    (ent_src2_value),
    .grant         (grant),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_tag     (issue_tag),
    .issue_a       (issue_a),
    .issue_b       (issue_b),
    .credit_return (credit_return)
  );

  alu_exec alu (
    .clk_in      (clk_in),
    .reset       (reset),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_tag   (issue_tag),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value)
  );

endmodule

`default_nettype wire

// ==== include/cluster_tb_tasks.svh ====
// scoreboard, xorshift source and operation driver for the cluster testbench
// included inside the testbench module after its DUT signals are declared

`ifndef CLUSTER_TB_TASKS_SVH
`define CLUSTER_TB_TASKS_SVH

logic [31:0]                         rng_state;
int                                  credits;
int                                  error_count;
int                                  results_seen;
logic [2**exec_pkg::TAG_BITS-1:0]    pending;
exec_pkg::data_t                     expected [2**exec_pkg::TAG_BITS];

function automatic logic [31:0] xorshift32();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic exec_pkg::data_t alu_model(
  input exec_pkg::alu_op_e op,
  input exec_pkg::data_t   a,
  input exec_pkg::data_t   b
);
  case (op)
    exec_pkg::ALU_ADD:  return a + b;
    exec_pkg::ALU_SUB:  return a - b;
    exec_pkg::ALU_AND:  return a & b;
    exec_pkg::ALU_OR:   return a | b;
    exec_pkg::ALU_XOR:  return a ^ b;
    exec_pkg::ALU_SLL:  return a << b[4:0];
    exec_pkg::ALU_SRL:  return a >> b[4:0];
    exec_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
    exec_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    exec_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
    default:            return '0;
  endcase
endfunction

// call on every clock edge where cdb_valid is high
function automatic void sb_cdb(input exec_pkg::tag_t t, input exec_pkg::data_t v);
  results_seen++;
  assert (pending[t] && v == expected[t]) else begin
    error_count++;
    $display("Fail at %0t: tag %0d gave %h, expected %h", $time, t, v, expected[t]);
  end
  pending[t] = 1'b0;
endfunction

// starts on a falling edge and returns on the next one
// a waiting operand carries a wrong value, only the CDB can supply the right one
task automatic send_op(
  input exec_pkg::alu_op_e op,
  input exec_pkg::tag_t    t,
  input logic              dep1,
  input exec_pkg::tag_t    s1,
  input exec_pkg::data_t   v1,
  input logic              dep2,
  input exec_pkg::tag_t    s2,
  input exec_pkg::data_t   v2
);
  int waited;
  waited = 0;
  while (credits == 0 && waited < 1000) begin
    @(negedge clk_in);
    waited++;
  end
  assert (credits > 0) else begin
    error_count++;
    $display("Fail at %0t: no credit for tag %0d", $time, t);
  end
  if (dep1) v1 = expected[s1];
  if (dep2) v2 = expected[s2];
  in_op         = op;
  in_tag        = t;
  in_src1_ready = !(dep1 && pending[s1]);
  in_src1_tag   = s1;
  in_src1_value = in_src1_ready ? v1 : ~v1;
  in_src2_ready = !(dep2 && pending[s2]);
  in_src2_tag   = s2;
  in_src2_value = in_src2_ready ? v2 : ~v2;
  in_valid      = 1'b1;
  credits--;
  expected[t] = alu_model(op, v1, v2);
  pending[t]  = 1'b1;
  @(negedge clk_in);
  in_valid = 1'b0;
endtask

task automatic wait_drain(input int limit);
  int waited;
  waited = 0;
  while (pending != '0 && waited < limit) begin
    @(negedge clk_in);
    waited++;
  end
  assert (pending == '0) else begin
    error_count++;
    $display("Fail at %0t: tags still pending %h", $time, pending);
  end
endtask

`endif

// ==== bench/exec_cluster_tb.sv ====
// directed testbench for the integer execution cluster
// drives operations under credits and scores every CDB result against a model

`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;

  logic              clk_in;
  logic              reset;
  logic              flush;
  logic              in_valid;
  exec_pkg::alu_op_e in_op;
  exec_pkg::tag_t    in_tag;
  logic              in_src1_ready;
  exec_pkg::tag_t    in_src1_tag;
  exec_pkg::data_t   in_src1_value;
  logic              in_src2_ready;
  exec_pkg::tag_t    in_src2_tag;
  exec_pkg::data_t   in_src2_value;
  wire               credit_return;
  wire               cdb_valid;
  wire exec_pkg::tag_t  cdb_tag;
  wire exec_pkg::data_t cdb_value;

  int tests_run;
  int tests_bad;
  int credit_pulses;

  `include "cluster_tb_tasks.svh"

  exec_cluster UUT (
    .clk_in        (clk_in),
    .reset         (reset),
    .flush         (flush),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_tag        (in_tag),
    .in_src1_ready (in_src1_ready),
    .in_src1_tag   (in_src1_tag),
    .in_src1_value (in_src1_value),
    .in_src2_ready (in_src2_ready),
    .in_src2_tag   (in_src2_tag),
    .in_src2_value (in_src2_value),
    .credit_return (credit_return),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value)
  );

  always #50 clk_in = ~clk_in;

  // score broadcasts and collect credits
  always @(posedge clk_in) begin
    if (!reset) begin
      if (cdb_valid) sb_cdb(cdb_tag, cdb_value);
      if (credit_return) begin
        credits++;
        credit_pulses++;
      end
      assert (credits <= exec_pkg::RS_ENTRIES) else begin
        error_count++;
        $display("More credits returned than were spent, now %0d", credits);
      end
    end
  end

  function automatic exec_pkg::tag_t pick_tag(input logic want_pending, output logic found);
    int             start;
    int             idx;
    exec_pkg::tag_t chosen;
    start  = int'(xorshift32() % (2**exec_pkg::TAG_BITS));
    found  = 1'b0;
    chosen = '0;
    for (int i = 0; i < 2**exec_pkg::TAG_BITS; i++) begin
      idx = (start + i) % (2**exec_pkg::TAG_BITS);
      if (!found && pending[idx] == want_pending) begin
        found  = 1'b1;
        chosen = exec_pkg::tag_t'(idx);
      end
    end
    return chosen;
  endfunction

  task automatic wait_credits(input int limit);
    int waited;
    waited = 0;
    while (credits != exec_pkg::RS_ENTRIES && waited < limit) begin
      @(negedge clk_in);
      waited++;
    end
    assert (credits == exec_pkg::RS_ENTRIES) else begin
      error_count++;
      $display("Credits did not come back in time, holding %0d", credits);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic check_counts(input int seen, input int pulses, input int n);
    assert (results_seen - seen == n && credit_pulses - pulses == n) else begin
      error_count++;
      $display("Fail at %0t: %0d results and %0d credits, expected %0d each", $time,
               results_seen - seen, credit_pulses - pulses, n);
    end
  endtask

  task automatic check_reset_state();
    int errs;
    errs = error_count;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_in);
      assert (!cdb_valid && !credit_return && UUT.ent_busy == '0) else begin
        error_count++;
        $display("Fail at %0t: cluster not idle after reset", $time);
      end
    end
    finish_test("reset state", errs);
  endtask

  task automatic check_independent();
    int errs;
    int seen;
    int pulses;
    errs   = error_count;
    seen   = results_seen;
    pulses = credit_pulses;
    // codes AND through SLTU, one each
    for (int i = 0; i < 8; i++) begin
      send_op(exec_pkg::alu_op_e'(i + 2), exec_pkg::tag_t'(i),
              1'b0, '0, xorshift32(), 1'b0, '0, xorshift32());
    end
    wait_drain(100);
    wait_credits(100);
    check_counts(seen, pulses, 8);
    finish_test("independent operations", errs);
  endtask

  task automatic check_chain();
    int errs;
    errs = error_count;
    send_op(exec_pkg::ALU_ADD, 4'd1, 1'b0, '0, 32'd100, 1'b0, '0, 32'd23);
    send_op(exec_pkg::ALU_SUB, 4'd2, 1'b1, 4'd1, '0, 1'b0, '0, 32'd7);
    // tag 1 is on the CDB while this one is sampled
    send_op(exec_pkg::ALU_XOR, 4'd3, 1'b1, 4'd1, '0, 1'b1, 4'd2, '0);
    send_op(exec_pkg::ALU_SLL, 4'd4, 1'b1, 4'd3, '0, 1'b0, '0, 32'd3);
    send_op(exec_pkg::ALU_OR,  4'd5, 1'b1, 4'd4, '0, 1'b1, 4'd2, '0);
    send_op(exec_pkg::ALU_SLT, 4'd6, 1'b1, 4'd2, '0, 1'b1, 4'd5, '0);
    wait_drain(100);
    wait_credits(100);
    finish_test("dependency chain", errs);
  endtask

  task automatic check_full_station();
    int              errs;
    int              seen;
    int              pulses;
    exec_pkg::data_t a;
    exec_pkg::data_t b;
    errs   = error_count;
    seen   = results_seen;
    pulses = credit_pulses;
    a      = xorshift32();
    b      = xorshift32();
    // producer tag 8 is announced before it is sent
    expected[8] = alu_model(exec_pkg::ALU_ADD, a, b);
    pending[8]  = 1'b1;
    for (int i = 0; i < 7; i++) begin
      send_op(exec_pkg::alu_op_e'(i), exec_pkg::tag_t'(9 + i),
              1'b1, 4'd8, '0, 1'b0, '0, xorshift32());
    end
    send_op(exec_pkg::ALU_ADD, 4'd8, 1'b0, '0, a, 1'b0, '0, b);
    wait_drain(200);
    wait_credits(100);
    check_counts(seen, pulses, 8);
    finish_test("full station", errs);
  endtask

  task automatic check_flush();
    int errs;
    int seen;
    int pulses;
    errs = error_count;
    // tag 0 is only produced after the flush
    expected[0] = 32'h0;
    pending[0]  = 1'b1;
    for (int i = 1; i <= 5; i++) begin
      send_op(exec_pkg::ALU_ADD, exec_pkg::tag_t'(i), 1'b1, 4'd0, '0, 1'b0, '0, xorshift32());
    end
    // tag 6 issues in the flush cycle
    send_op(exec_pkg::ALU_OR, 4'd6, 1'b0, '0, xorshift32(), 1'b0, '0, xorshift32());
    flush = 1'b1;
    @(negedge clk_in);
    flush   = 1'b0;
    pending = '0;
    credits = exec_pkg::RS_ENTRIES;
    seen    = results_seen;
    pulses  = credit_pulses;
    for (int i = 0; i < 30; i++) begin
      @(negedge clk_in);
    end
    assert (UUT.ent_busy == '0) else begin
      error_count++;
      $display("Reservation entries still busy after flush");
    end
    // stale entries would wake on tag 0 and broadcast
    send_op(exec_pkg::ALU_SRA, 4'd0, 1'b0, '0, 32'h8000_0f00, 1'b0, '0, 32'd4);
    send_op(exec_pkg::ALU_SRL, 4'd2, 1'b0, '0, 32'h8000_0f00, 1'b0, '0, 32'd36);
    send_op(exec_pkg::ALU_SLTU, 4'd3, 1'b1, 4'd0, '0, 1'b1, 4'd2, '0);
    wait_drain(100);
    wait_credits(100);
    check_counts(seen, pulses, 3);
    finish_test("flush", errs);
  endtask

  task automatic check_random();
    int             errs;
    exec_pkg::tag_t t;
    exec_pkg::tag_t s1;
    exec_pkg::tag_t s2;
    logic           d1;
    logic           d2;
    logic           found;
    errs = error_count;
    for (int n = 0; n < 200; n++) begin
      t  = pick_tag(1'b0, found);
      d1 = 1'b0;
      d2 = 1'b0;
      s1 = '0;
      s2 = '0;
      assert (found) else begin
        error_count++;
        $display("No free tag for random operation %0d", n);
      end
      if ((xorshift32() & 32'd1) != 0) s1 = pick_tag(1'b1, d1);
      if ((xorshift32() & 32'd1) != 0) s2 = pick_tag(1'b1, d2);
      send_op(exec_pkg::alu_op_e'(xorshift32() % 10), t, d1, s1, xorshift32(),
              d2, s2, xorshift32());
    end
    wait_drain(300);
    wait_credits(100);
    finish_test("random traffic", errs);
  endtask

  initial begin
    clk_in        = 1'b0;
    reset         = 1'b1;
    flush         = 1'b0;
    in_valid      = 1'b0;
    in_op         = exec_pkg::ALU_ADD;
    in_tag        = '0;
    in_src1_ready = 1'b0;
    in_src1_tag   = '0;
    in_src1_value = '0;
    in_src2_ready = 1'b0;
    in_src2_tag   = '0;
    in_src2_value = '0;
    rng_state     = 32'd82;
    credits       = exec_pkg::RS_ENTRIES;
    error_count   = 0;
    results_seen  = 0;
    credit_pulses = 0;
    tests_run     = 0;
    tests_bad     = 0;
    pending       = '0;
    for (int i = 0; i < 2**exec_pkg::TAG_BITS; i++) begin
      expected[i] = '0;
    end
    repeat (10) @(negedge clk_in);
    reset = 1'b0;
    check_reset_state();
    check_independent();
    check_chain();
    check_full_station();
    check_flush();
    check_random();
    $display("tests run %0d, with errors %0d, failed checks %0d, results scored %0d",
             tests_run, tests_bad, error_count, results_seen);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== exec_cluster.f ====
+incdir+include
verilog/exec_pkg.sv
verilog/rs_dispatch.sv
verilog/rs_entry.sv
verilog/rs_issue_select.sv
verilog/alu_exec.sv
verilog/exec_cluster.sv
bench/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execution cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f exec_cluster.f --top-module exec_cluster_tb -o sim_exec_cluster
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit 1
fi

output=$(./obj_dir/sim_exec_cluster)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1
